/* sim.f */
rtl/asg_pkg.sv
rtl/asg_ext_trig.sv
rtl/asg_channel.sv
rtl/asg_regs.sv
rtl/asg_dac_mix.sv
rtl/asg_top.sv
verification/asg_assert.sv
verification/asg_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the run by the log
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module asg_tb -o asg_sim \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/asg_sim > sim.log 2>&1 || echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && { echo "simulation FAILED"; exit 1; } || echo "simulation ok"
exit 0

/* verification/asg_tb.sv */
// testbench for the two channel generator, host bus tasks and a scale model
// drives the bus and trigger, checks readback and dac samples
`default_nettype none

module asg_tb;
   import asg_pkg::*;

   // rough cycle budget per test, bus op ~8 cycles
   localparam int T1_CYC = 28 * 8;
   localparam int T2_CYC = 64 * 8;
   localparam int T3_CYC = 16 * 8 + 60;
   localparam int T4_CYC = 13 * 8 + 80;
   localparam int T5_CYC = 12 * 8 + 80;
   localparam int T6_CYC = 17 * 8 + 3 * 40 + 2 * 250 + 100;
   localparam int LIMIT  = (T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC) * 12 / 10;

   logic             dac_clk_i;
   logic             dac_rstn_i;
   logic             req_i;
   bus_req_t         bus_i;
   logic             ack_o;
   logic [31:0]      rdata_o;
   logic             trig_ext_i;
   logic             trig_done_a_o;
   logic             trig_done_b_o;
   logic [DAC_W-1:0] dac_o;

   int               seed = 51674;
   int               err_cnt = 0;
   int               chk_cnt = 0;
   int               cyc = 0;
   int               done_a_cnt = 0;
   int               done_b_cnt = 0;
   logic [DAC_W-1:0] tbl [2][16];     // table model, 16 words per channel
   logic [31:0]      rd;
   logic [31:0]      mask [7];

   asg_top UUT (.*);

   initial begin
      dac_clk_i = 1'b0;
      forever #10 dac_clk_i = ~dac_clk_i;
   end

   always @(negedge dac_clk_i) begin
      if (trig_done_a_o) done_a_cnt++;
      if (trig_done_b_o) done_b_cnt++;
   end

   initial begin                       // run limit
      while (cyc < LIMIT) @(posedge dac_clk_i) cyc++;
      $display("timeout after %0d cycles, run did not finish", cyc);
      $display("test failed");
      $finish;
   end

   // ----------------------------------------
   // model and checks
   function automatic int sat14(input int v);
      if (v > 8191) return 8191;
      if (v < -8192) return -8192;
      return v;
   endfunction

   // sample * amp >>> 13 + dc, clamped
   function automatic int scale_ref(input logic [13:0] s, input logic [13:0] amp,
                                    input logic [13:0] dc);
      int sv;
      int av;
      int dv;
      sv = $signed(s);
      av = amp;                        // unsigned gain
      dv = $signed(dc);
      return sat14(((sv * av) >>> 13) + dv);
   endfunction

   function automatic logic [DAC_W-1:0] to_dac(input int v);
      return v[DAC_W-1:0];
   endfunction

   function automatic logic [11:0] reg_addr(input logic ch, input int idx);
      return {1'b0, ch, 7'd0, 3'(idx)};
   endfunction

   function automatic logic [11:0] tbl_addr(input logic ch, input int i);
      return {1'b1, ch, 10'(i)};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      assert (got == exp) else begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   // one four-phase transfer
   task automatic bus_xfer(input logic we, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
      int n;
      n = 0;
      @(posedge dac_clk_i); #1;
      bus_i = '{we: we, addr: addr, wdata: wdata};
      req_i = 1'b1;
      while (!ack_o && n < 20) begin
         @(negedge dac_clk_i);
         n++;
      end
      rdata = rdata_o;
      if (n == 20) begin
         $display("bus request at address %h got no ack", addr);
         err_cnt++;
      end
      @(posedge dac_clk_i); #1;
      req_i = 1'b0;
      n = 0;
      while (ack_o && n < 20) begin
         @(negedge dac_clk_i);
         n++;
      end
      if (n == 20) begin
         $display("ack stayed high after req was released, address %h", addr);
         err_cnt++;
      end
   endtask

   task automatic wr(input logic [11:0] addr, input logic [31:0] wdata);
      logic [31:0] dummy;
      bus_xfer(1'b1, addr, wdata, dummy);
   endtask

   task automatic config_chan(input logic ch, input int size, input int step, input int ofs,
                              input logic [13:0] amp, input logic [13:0] dc, input int ncyc,
                              input int rnum, input int rdly);
      wr(reg_addr(ch, SIZE), size << 16);
      wr(reg_addr(ch, STEP), step << 16);
      wr(reg_addr(ch, OFS), ofs << 16);
      wr(reg_addr(ch, AMP_DC), {2'b00, dc, 2'b00, amp});
      wr(reg_addr(ch, NCYC), ncyc);
      wr(reg_addr(ch, RNUM), rnum);
      wr(reg_addr(ch, RDLY), rdly);
   endtask

   // wait for a static value, then check it holds
   task automatic wait_dac(input logic [DAC_W-1:0] exp, input string what);
      int n;
      n = 0;
      while (dac_o != exp && n < 20) begin
         @(negedge dac_clk_i);
         n++;
      end
      repeat (3) begin
         check_val(what, 32'(dac_o), 32'(exp));
         @(negedge dac_clk_i);
      end
   endtask

   // one table pass at unity gain, aligned on the first nonzero word
   task automatic play_check(input logic ch);
      int n;
      n = 0;
      while (dac_o == '0 && n < 400) begin
         @(negedge dac_clk_i);
         n++;
      end
      if (n == 400) begin
         $display("channel %0d playback never started", ch);
         err_cnt++;
      end
      for (int i = 1; i < 16; i++) begin
         check_val("dac_o", 32'(dac_o), 32'(to_dac(scale_ref(tbl[ch][i], 14'h2000, 14'h0))));
         @(negedge dac_clk_i);
      end
      repeat (3) begin                 // holds on word 0 afterwards
         check_val("dac_o", 32'(dac_o), 32'h0);
         @(negedge dac_clk_i);
      end
   endtask

   // external trigger high for two cycles
   task automatic ext_pulse();
      @(posedge dac_clk_i); #1;
      trig_ext_i = 1'b1;
      repeat (2) @(posedge dac_clk_i);
      #1 trig_ext_i = 1'b0;
   endtask

   // ----------------------------------------
   // stimulus
   initial begin
      dac_rstn_i = 1'b0;
      req_i      = 1'b0;
      bus_i      = '0;
      trig_ext_i = 1'b0;
      mask       = '{32'h03ff_ffff, 32'h03ff_ffff, 32'h03ff_ffff, 32'h3fff_3fff,
                     32'h0000_ffff, 32'h0000_ffff, 32'hffff_ffff};
      repeat (2) @(posedge dac_clk_i);
      #1 dac_rstn_i = 1'b1;

      // 1: register readback
      for (int ch = 0; ch < 2; ch++) begin
         for (int r = 0; r < 7; r++) begin
            logic [31:0] w;
            w = $random(seed);
            wr(reg_addr(ch, r), w);
            bus_xfer(1'b0, reg_addr(ch, r), 32'h0, rd);
            check_val("rdata_o", rd, w & mask[r]);
         end
      end

      // 2: table readback, words kept nonzero
      for (int ch = 0; ch < 2; ch++) begin
         for (int i = 0; i < 16; i++) begin
            tbl[ch][i] = 14'($random(seed));
            if (tbl[ch][i] == '0) tbl[ch][i] = 14'h1;
            wr(tbl_addr(ch, i), tbl[ch][i]);
            bus_xfer(1'b0, tbl_addr(ch, i), 32'h0, rd);
            check_val("rdata_o", rd, 32'(tbl[ch][i]));
         end
      end

      // 3: channel a one pass, sw trigger
      config_chan(0, 15, 1, 0, 14'h2000, 14'h0, 1, 0, 0);
      tbl[0][0] = '0;
      wr(tbl_addr(0, 0), 32'h0);
      wr(reg_addr(0, CTRL), 32'h12);   // rst, src sw, mix a
      wait_dac(14'h0, "dac_o");
      done_a_cnt = 0;
      wr(reg_addr(0, CTRL), 32'h11);   // sw trigger
      play_check(0);
      check_val("trig_done_a_o count", done_a_cnt, 1);

      // 4: saturation both ways, then zero flag
      tbl[0][5] = 14'h1000;
      tbl[0][6] = 14'h3000;
      wr(tbl_addr(0, 5), tbl[0][5]);
      wr(tbl_addr(0, 6), tbl[0][6]);
      wr(reg_addr(0, OFS), 5 << 16);
      wr(reg_addr(0, CTRL), 32'h12);
      wait_dac(to_dac(scale_ref(tbl[0][5], 14'h2000, 14'h0)), "dac_o");
      wr(reg_addr(0, AMP_DC), {2'b00, 14'h1fff, 2'b00, 14'h2000});
      wait_dac(to_dac(scale_ref(tbl[0][5], 14'h2000, 14'h1fff)), "dac_o high clamp");
      wr(reg_addr(0, OFS), 6 << 16);
      wr(reg_addr(0, AMP_DC), {2'b00, 14'h2000, 2'b00, 14'h2000});
      wr(reg_addr(0, CTRL), 32'h12);
      wait_dac(to_dac(scale_ref(tbl[0][6], 14'h2000, 14'h2000)), "dac_o low clamp");
      wr(reg_addr(0, CTRL), 32'h1a);   // zero flag
      wait_dac(14'h0, "dac_o zero flag");

      // 5: mixer sum and zero
      wr(reg_addr(0, OFS), 5 << 16);
      wr(reg_addr(0, AMP_DC), {2'b00, 14'h0, 2'b00, 14'h2000});
      tbl[1][5] = 14'h1800;
      wr(tbl_addr(1, 5), tbl[1][5]);
      config_chan(1, 15, 1, 5, 14'h2000, 14'h0, 1, 0, 0);
      wr(reg_addr(1, CTRL), 32'h02);
      wr(reg_addr(0, CTRL), 32'h212);  // mix sum
      wait_dac(to_dac(sat14(scale_ref(tbl[0][5], 14'h2000, 14'h0)
                            + scale_ref(tbl[1][5], 14'h2000, 14'h0))), "dac_o sum");
      wr(reg_addr(1, AMP_DC), {2'b00, 14'h3000, 2'b00, 14'h2000});
      wait_dac(to_dac(sat14(scale_ref(tbl[0][5], 14'h2000, 14'h0)
                            + scale_ref(tbl[1][5], 14'h2000, 14'h3000))), "dac_o sum");
      wr(reg_addr(0, CTRL), 32'h310);  // mix zero
      wait_dac(14'h0, "dac_o mix zero");

      // 6: channel b on external edge, bounce ignored, two repeats
      wr(reg_addr(0, CTRL), 32'h110);  // mix b
      config_chan(1, 15, 1, 0, 14'h2000, 14'h0, 1, 2, 1);
      tbl[1][0] = '0;
      wr(tbl_addr(1, 0), 32'h0);
      wr(reg_addr(1, CTRL), 32'h22);   // rst, src ext rising
      wait_dac(14'h0, "dac_o");
      done_b_cnt = 0;
      ext_pulse();
      wr(reg_addr(1, CTRL), 32'h22);   // b back to idle, hold window still running
      ext_pulse();                     // bounce inside hold window
      repeat (20) @(negedge dac_clk_i);
      check_val("trig_done_b_o count", done_b_cnt, 1);
      ext_pulse();
      repeat (3) play_check(1);
      check_val("trig_done_b_o count", done_b_cnt, 2);

      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verification/asg_assert.sv */
// concurrent checks on the host handshake and the dac output after reset
// bound to asg_top, reports only through failing assertions
`default_nettype none

module asg_assert (
   input logic                      dac_clk_i,
   input logic                      dac_rstn_i,
   input logic                      req_i,
   input logic                      ack_o,
   input logic [asg_pkg::DAC_W-1:0] dac_o
);
   import asg_pkg::*;

   // ----------------------------------------
   // four-phase handshake
   property ack_rise_with_req;
      @(posedge dac_clk_i) disable iff (!dac_rstn_i)
         $rose(ack_o) |-> req_i;
   endproperty

   property ack_fall_after_req;
      @(posedge dac_clk_i) disable iff (!dac_rstn_i)
         $fell(ack_o) |-> !$past(req_i);   // req already low one cycle before
   endproperty

   a_ack_rise : assert property (ack_rise_with_req)
      else $error("ack rose while req was low");
   a_ack_fall : assert property (ack_fall_after_req)
      else $error("ack dropped before req was released");

   // ----------------------------------------
   // dac word cleared by reset
   a_dac_rst : assert property (@(posedge dac_clk_i) !dac_rstn_i |=> dac_o == '0)
      else $error("dac word not zero during reset");
   a_dac_post : assert property (@(posedge dac_clk_i) $rose(dac_rstn_i) |=> dac_o == '0)
      else $error("dac word not zero on the cycle after reset");

endmodule

bind asg_top asg_assert i_assert (
   .dac_clk_i  (dac_clk_i),
   .dac_rstn_i (dac_rstn_i),
   .req_i      (req_i),
   .ack_o      (ack_o),
   .dac_o      (dac_o)
);

`default_nettype wire

/* rtl/asg_top.sv */
// two channel signal generator top, host bus in, one dac word out
`default_nettype none

module asg_top (
   input  logic                      dac_clk_i,
   input  logic                      dac_rstn_i,
   input  logic                      req_i,
   input  asg_pkg::bus_req_t         bus_i,
   output logic                      ack_o,
   output logic [31:0]               rdata_o,
   input  logic                      trig_ext_i,
   output logic                      trig_done_a_o,
   output logic                      trig_done_b_o,
   output logic [asg_pkg::DAC_W-1:0] dac_o
);
   import asg_pkg::*;

   chan_cfg_t               cfg_a;
   chan_cfg_t               cfg_b;
   buf_port_t               buf_a;
   buf_port_t               buf_b;
   logic [DAC_W-1:0]        buf_rdata_a;
   logic [DAC_W-1:0]        buf_rdata_b;
   logic [BUF_AW-1:0]       rpnt_a;
   logic [BUF_AW-1:0]       rpnt_b;
   logic                    trig_sw_a;
   logic                    trig_sw_b;
   logic                    ext_pos;     // conditioned, shared by a and b
   logic                    ext_neg;
   mix_mode_e               mix_mode;
   logic signed [DAC_W-1:0] dat_a;
   logic signed [DAC_W-1:0] dat_b;

   // ----------------------------------------
   // control
   asg_regs i_regs (
      .dac_clk_i     (dac_clk_i),
      .dac_rstn_i    (dac_rstn_i),
      .req_i         (req_i),
      .bus_i         (bus_i),
      .ack_o         (ack_o),
      .rdata_o       (rdata_o),
      .cfg_a_o       (cfg_a),
      .cfg_b_o       (cfg_b),
      .buf_a_o       (buf_a),
      .buf_b_o       (buf_b),
      .buf_rdata_a_i (buf_rdata_a),
      .buf_rdata_b_i (buf_rdata_b),
      .rpnt_a_i      (rpnt_a),
      .rpnt_b_i      (rpnt_b),
      .trig_sw_a_o   (trig_sw_a),
      .trig_sw_b_o   (trig_sw_b),
      .mix_mode_o    (mix_mode)
   );

   asg_ext_trig i_ext_trig (
      .dac_clk_i  (dac_clk_i),
      .dac_rstn_i (dac_rstn_i),
      .trig_ext_i (trig_ext_i),
      .ext_pos_o  (ext_pos),
      .ext_neg_o  (ext_neg)
   );

   // ----------------------------------------
   // channels and output
   asg_channel i_ch_a (
      .dac_clk_i   (dac_clk_i),
      .dac_rstn_i  (dac_rstn_i),
      .cfg_i       (cfg_a),
      .buf_i       (buf_a),
      .buf_rdata_o (buf_rdata_a),
      .rpnt_o      (rpnt_a),
      .trig_sw_i   (trig_sw_a),
      .ext_pos_i   (ext_pos),
      .ext_neg_i   (ext_neg),
      .trig_done_o (trig_done_a_o),
      .dat_o       (dat_a)
   );

   asg_channel i_ch_b (
      .dac_clk_i   (dac_clk_i),
      .dac_rstn_i  (dac_rstn_i),
      .cfg_i       (cfg_b),
      .buf_i       (buf_b),
      .buf_rdata_o (buf_rdata_b),
      .rpnt_o      (rpnt_b),
      .trig_sw_i   (trig_sw_b),
      .ext_pos_i   (ext_pos),
      .ext_neg_i   (ext_neg),
      .trig_done_o (trig_done_b_o),
      .dat_o       (dat_b)
   );

   asg_dac_mix i_mix (
      .dac_clk_i  (dac_clk_i),
      .dac_rstn_i (dac_rstn_i),
      .mode_i     (mix_mode),
      .dat_a_i    (dat_a),
      .dat_b_i    (dat_b),
      .dac_o      (dac_o)
   );

endmodule

`default_nettype wire

/* rtl/asg_dac_mix.sv */
// output mixer, picks a, b, zero or the clamped sum a+b
// registered dac word, one cycle
`default_nettype none

module asg_dac_mix (
   input  logic                             dac_clk_i,
   input  logic                             dac_rstn_i,
   input  asg_pkg::mix_mode_e               mode_i,
   input  logic signed [asg_pkg::DAC_W-1:0] dat_a_i,
   input  logic signed [asg_pkg::DAC_W-1:0] dat_b_i,
   output logic [asg_pkg::DAC_W-1:0]        dac_o
);
   import asg_pkg::*;

   logic signed [DAC_W+1:0] sum_ab;   // two guard bits, no wrap

   assign sum_ab = dat_a_i + dat_b_i;

   always_ff @(posedge dac_clk_i) begin
      if (!dac_rstn_i) begin
         dac_o <= '0;
      end else begin
         case (mode_i)
            MIX_A:   dac_o <= dat_a_i;
            MIX_B:   dac_o <= dat_b_i;
            MIX_SUM: dac_o <= sat_dac(sum_ab);
            default: dac_o <= '0;      // MIX_ZERO
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/asg_regs.sv */
// host register slave, four-phase req/ack
// CTRL: [0] sw trig, [1] rst, [2] wrap, [3] zero, [6:4] src, [9:8] mix (ch a)
`default_nettype none

module asg_regs (
   input  logic                        dac_clk_i,
   input  logic                        dac_rstn_i,
   input  logic                        req_i,
   input  asg_pkg::bus_req_t           bus_i,
   output logic                        ack_o,
   output logic [31:0]                 rdata_o,
   output asg_pkg::chan_cfg_t          cfg_a_o,
   output asg_pkg::chan_cfg_t          cfg_b_o,
   output asg_pkg::buf_port_t          buf_a_o,
   output asg_pkg::buf_port_t          buf_b_o,
   input  logic [asg_pkg::DAC_W-1:0]   buf_rdata_a_i,
   input  logic [asg_pkg::DAC_W-1:0]   buf_rdata_b_i,
   input  logic [asg_pkg::BUF_AW-1:0]  rpnt_a_i,
   input  logic [asg_pkg::BUF_AW-1:0]  rpnt_b_i,
   output logic                        trig_sw_a_o,
   output logic                        trig_sw_b_o,
   output asg_pkg::mix_mode_e          mix_mode_o
);
   import asg_pkg::*;

   typedef enum logic [1:0] {IDLE, WAIT_RD, ACK} bus_st_e;

   bus_st_e           state;
   logic              req_q;
   logic              ch;                // 0 = channel a
   reg_idx_e          idx;
   chan_cfg_t         cfg_q [2];
   logic              trig_q [2];
   logic              buf_we_q [2];
   logic [BUF_AW-1:0] buf_addr_q;        // shared by both tables
   logic [DAC_W-1:0]  buf_wdata_q;
   mix_mode_e         mix_q;
   logic [DAC_W-1:0]  buf_rdata [2];
   logic [BUF_AW-1:0] rpnt [2];
   logic [31:0]       reg_rdata;

   assign ch  = bus_i.addr[BUF_AW];
   assign idx = bus_i.addr[BUF_AW+1] ? TABLE : reg_idx_e'({1'b0, bus_i.addr[2:0]});

   assign buf_rdata[0] = buf_rdata_a_i;
   assign buf_rdata[1] = buf_rdata_b_i;
   assign rpnt[0]      = rpnt_a_i;
   assign rpnt[1]      = rpnt_b_i;

   assign cfg_a_o     = cfg_q[0];
   assign cfg_b_o     = cfg_q[1];
   assign trig_sw_a_o = trig_q[0];
   assign trig_sw_b_o = trig_q[1];
   assign mix_mode_o  = mix_q;
   assign buf_a_o     = '{we: buf_we_q[0], addr: buf_addr_q, wdata: buf_wdata_q};
   assign buf_b_o     = '{we: buf_we_q[1], addr: buf_addr_q, wdata: buf_wdata_q};

   // ----------------------------------------
   // register read mux
   always_comb begin
      reg_rdata = '0;
      case (idx)
         SIZE:   reg_rdata[PNT_W-1:0] = cfg_q[ch].size;
         STEP:   reg_rdata[PNT_W-1:0] = cfg_q[ch].step;
         OFS:    reg_rdata[PNT_W-1:0] = cfg_q[ch].ofs;
         AMP_DC: reg_rdata = {2'b00, cfg_q[ch].dc, 2'b00, cfg_q[ch].amp};
         NCYC:   reg_rdata[15:0] = cfg_q[ch].ncyc;
         RNUM:   reg_rdata[15:0] = cfg_q[ch].rnum;
         RDLY:   reg_rdata = cfg_q[ch].rdly;
         CTRL: begin
            reg_rdata[16 +: BUF_AW] = rpnt[ch];             // live pointer
            reg_rdata[6:2] = {cfg_q[ch].trig_src, cfg_q[ch].zero, cfg_q[ch].wrap};
            if (!ch)
               reg_rdata[9:8] = mix_q;
         end
         default: reg_rdata = '0;
      endcase
   end

   // table address/data, no reset needed
   always_ff @(posedge dac_clk_i) begin
      buf_addr_q  <= bus_i.addr[BUF_AW-1:0];   // ready before read-back
      buf_wdata_q <= bus_i.wdata[DAC_W-1:0];
   end

   // ----------------------------------------
   // handshake FSM and register writes
   always_ff @(posedge dac_clk_i) begin
      if (!dac_rstn_i) begin
         state   <= IDLE;
         req_q   <= 1'b0;
         ack_o   <= 1'b0;
         rdata_o <= '0;
         mix_q   <= MIX_A;
         for (int i = 0; i < 2; i++) begin
            cfg_q[i]    <= '0;
            trig_q[i]   <= 1'b0;
            buf_we_q[i] <= 1'b0;
         end
      end else begin
         req_q <= req_i;
         for (int i = 0; i < 2; i++) begin       // pulses last one cycle
            trig_q[i]     <= 1'b0;
            buf_we_q[i]   <= 1'b0;
            cfg_q[i].rst  <= 1'b0;
         end
         case (state)
            IDLE: begin
               if (req_q) begin
                  if (idx == TABLE) begin
                     buf_we_q[ch] <= bus_i.we;
                     ack_o        <= bus_i.we;
                     state        <= bus_i.we ? ACK : WAIT_RD;
                  end else begin
                     if (bus_i.we) begin
                        case (idx)
                           SIZE:   cfg_q[ch].size <= bus_i.wdata[PNT_W-1:0];
                           STEP:   cfg_q[ch].step <= bus_i.wdata[PNT_W-1:0];
                           OFS:    cfg_q[ch].ofs  <= bus_i.wdata[PNT_W-1:0];
                           AMP_DC: begin
                              cfg_q[ch].amp <= bus_i.wdata[DAC_W-1:0];
                              cfg_q[ch].dc  <= bus_i.wdata[16 +: DAC_W];
                           end
                           NCYC:   cfg_q[ch].ncyc <= bus_i.wdata[15:0];
                           RNUM:   cfg_q[ch].rnum <= bus_i.wdata[15:0];
                           RDLY:   cfg_q[ch].rdly <= bus_i.wdata;
                           CTRL: begin
                              trig_q[ch]         <= bus_i.wdata[0];
                              cfg_q[ch].rst      <= bus_i.wdata[1];
                              cfg_q[ch].wrap     <= bus_i.wdata[2];
                              cfg_q[ch].zero     <= bus_i.wdata[3];
                              cfg_q[ch].trig_src <= trig_src_e'(bus_i.wdata[6:4]);
                              if (!ch)
                                 mix_q <= mix_mode_e'(bus_i.wdata[9:8]);
                           end
                           default: ;
                        endcase
                     end
                     rdata_o <= reg_rdata;
                     ack_o   <= 1'b1;
                     state   <= ACK;
                  end
               end
            end
            WAIT_RD: begin                         // table read-back now valid
               rdata_o <= {{(32-DAC_W){1'b0}}, buf_rdata[ch]};
               ack_o   <= 1'b1;
               state   <= ACK;
            end
            ACK: begin
               if (!req_q) begin                   // host released, close cycle
                  ack_o <= 1'b0;
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/asg_channel.sv */
// one generator channel: sample table, trigger/cycle/repeat FSM,
// fixed point pointer and scale/offset/saturate stage
`default_nettype none

module asg_channel (
   input  logic                             dac_clk_i,
   input  logic                             dac_rstn_i,
   input  asg_pkg::chan_cfg_t               cfg_i,
   input  asg_pkg::buf_port_t               buf_i,
   output logic [asg_pkg::DAC_W-1:0]        buf_rdata_o,
   output logic [asg_pkg::BUF_AW-1:0]       rpnt_o,
   input  logic                             trig_sw_i,
   input  logic                             ext_pos_i,
   input  logic                             ext_neg_i,
   output logic                             trig_done_o,
   output logic signed [asg_pkg::DAC_W-1:0] dat_o
);
   import asg_pkg::*;

   typedef enum logic [1:0] {CH_IDLE, CH_RUN, CH_DELAY} ch_st_e;

   // ----------------------------------------
   // sample table
   logic [DAC_W-1:0]        buf_mem [2**BUF_AW];
   logic [BUF_AW-1:0]       rp;
   logic [DAC_W-1:0]        rd;
   logic [DAC_W-1:0]        rdat;
   logic signed [2*DAC_W:0] mult;
   logic signed [DAC_W+1:0] sum;

   logic [PNT_W-1:0]        pnt;

   always_ff @(posedge dac_clk_i) begin
      if (buf_i.we)
         buf_mem[buf_i.addr] <= buf_i.wdata;     // host write port
      buf_rdata_o <= buf_mem[buf_i.addr];        // host read-back
      rpnt_o      <= pnt[PNT_W-1 -: BUF_AW];
      rp          <= pnt[PNT_W-1 -: BUF_AW];     // integer part only
      rd          <= buf_mem[rp];                // stepping port
      rdat        <= rd;                         // extra stage for timing
   end

   // ----------------------------------------
   // scale, offset, saturate
   always_ff @(posedge dac_clk_i) begin
      if (!dac_rstn_i) begin
         mult  <= '0;
         sum   <= '0;
         dat_o <= '0;
      end else begin
         mult  <= $signed(rdat) * $signed({1'b0, cfg_i.amp});
         sum   <= $signed(mult[2*DAC_W:DAC_W-1]) + $signed(cfg_i.dc);   // >>> 13
         dat_o <= cfg_i.zero ? '0 : sat_dac(sum);
      end
   end

   // ----------------------------------------
   // pointer and sequencing FSM
   ch_st_e            state;
   logic              trig_in;       // selected trigger, registered
   logic [PNT_W+1:0]  npnt;
   logic [PNT_W+1:0]  npnt_sub;
   logic              wrap_hit;      // next step passes size
   logic [15:0]       cyc_cnt;
   logic [15:0]       rep_cnt;
   logic [31:0]       dly_cnt;
   logic [TICK_W-1:0] tick;

   assign npnt     = {2'b00, pnt} + {2'b00, cfg_i.step};
   assign npnt_sub = npnt - {2'b00, cfg_i.size} - 1'b1;
   assign wrap_hit = !npnt_sub[PNT_W+1];

   // only a fresh start reports, restarts from repetition do not
   assign trig_done_o = (state == CH_IDLE) && trig_in;

   always_ff @(posedge dac_clk_i) begin
      if (!dac_rstn_i) begin
         state   <= CH_IDLE;
         trig_in <= 1'b0;
         pnt     <= '0;
         cyc_cnt <= '0;
         rep_cnt <= '0;
         dly_cnt <= '0;
         tick    <= '0;
      end else begin
         case (cfg_i.trig_src)
            SW:      trig_in <= trig_sw_i;
            EXT_POS: trig_in <= ext_pos_i;
            EXT_NEG: trig_in <= ext_neg_i;
            default: trig_in <= 1'b0;
         endcase

         if (cfg_i.rst) begin                     // manual reset
            state <= CH_IDLE;
            pnt   <= cfg_i.ofs;
         end else begin
            case (state)
               CH_IDLE: begin
                  if (trig_in) begin
                     rep_cnt <= cfg_i.rnum;
                     cyc_cnt <= cfg_i.ncyc;
                     pnt     <= cfg_i.ofs;
                     state   <= CH_RUN;
                  end
               end
               CH_RUN: begin
                  if (wrap_hit) begin
                     // wrap keeps the fraction, else back to start
                     pnt <= cfg_i.wrap ? npnt_sub[PNT_W-1:0] : cfg_i.ofs;
                     if (cyc_cnt == 16'd1) begin          // last table cycle
                        tick    <= '0;
                        dly_cnt <= cfg_i.rdly;
                        state   <= (rep_cnt != '0) ? CH_DELAY : CH_IDLE;
                     end else if (cyc_cnt != '0) begin   // ncyc 0 runs forever
                        cyc_cnt <= cyc_cnt - 16'd1;
                     end
                  end else begin
                     pnt <= npnt[PNT_W-1:0];
                  end
               end
               CH_DELAY: begin
                  if (dly_cnt == '0) begin               // next repetition
                     rep_cnt <= rep_cnt - 16'd1;
                     cyc_cnt <= cfg_i.ncyc;
                     pnt     <= cfg_i.ofs;
                     state   <= CH_RUN;
                  end else if (tick == TICK_W'(TICK_DIV - 1)) begin
                     tick    <= '0;
                     dly_cnt <= dly_cnt - 32'd1;
                  end else begin
                     tick <= tick + 1'b1;
                  end
               end
               default: state <= CH_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/asg_ext_trig.sv */
// external trigger conditioner, shared by both channels
// sync + debounce, one-cycle pulses per edge
`default_nettype none

module asg_ext_trig (
   input  logic dac_clk_i,
   input  logic dac_rstn_i,
   input  logic trig_ext_i,
   output logic ext_pos_o,
   output logic ext_neg_o
);
   import asg_pkg::*;

   logic [2:0]       sync;     // [1] is the clean level, [2] one older
   logic [DEB_W-1:0] deb_p;
   logic [DEB_W-1:0] deb_n;
   logic [1:0]       held_p;   // held level, rising side
   logic [1:0]       held_n;   // held level, falling side

   always_ff @(posedge dac_clk_i) begin
      if (!dac_rstn_i) begin
         sync      <= '0;
         deb_p     <= '0;
         deb_n     <= '0;
         held_p    <= '0;
         held_n    <= '0;
         ext_pos_o <= 1'b0;
         ext_neg_o <= 1'b0;
      end else begin
         sync <= {sync[1:0], trig_ext_i};

         // hold off further edges for DEB_CYC cycles
         if (deb_p == '0 && sync[1] && !sync[2])
            deb_p <= DEB_W'(DEB_CYC);
         else if (deb_p != '0)
            deb_p <= deb_p - 1'b1;

         if (deb_n == '0 && !sync[1] && sync[2])
            deb_n <= DEB_W'(DEB_CYC);
         else if (deb_n != '0)
            deb_n <= deb_n - 1'b1;

         // level only sampled while counter idle
         held_p <= {held_p[0], (deb_p == '0) ? sync[1] : held_p[0]};
         held_n <= {held_n[0], (deb_n == '0) ? sync[1] : held_n[0]};

         ext_pos_o <= (held_p == 2'b01);
         ext_neg_o <= (held_n == 2'b10);
      end
   end

endmodule

`default_nettype wire

/* rtl/asg_pkg.sv */
// shared sizes, enums and bus/config structs of the signal generator
// imported by every RTL block and by the testbench
`default_nettype none

package asg_pkg;

   // ----------------------------------------
   // sizes
   localparam int DAC_W    = 14;                  // sample / dac word
   localparam int BUF_AW   = 10;                  // table address bits
   localparam int FRAC_W   = 16;                  // pointer fraction bits
   localparam int PNT_W    = BUF_AW + FRAC_W;     // fixed point read pointer
   localparam int TICK_DIV = 125;                 // clocks per delay tick
   localparam int TICK_W   = $clog2(TICK_DIV);
   localparam int DEB_CYC  = 16;                  // debounce hold, cycles
   localparam int DEB_W    = $clog2(DEB_CYC + 1);

   // ----------------------------------------
   // enums
   typedef enum logic [2:0] {
      NONE    = 3'd0,
      SW      = 3'd1,   // CTRL write
      EXT_POS = 3'd2,   // external rising edge
      EXT_NEG = 3'd3    // external falling edge
   } trig_src_e;

   typedef enum logic [1:0] {MIX_A, MIX_B, MIX_SUM, MIX_ZERO} mix_mode_e;

   // per channel register map, TABLE when addr[11] set
   typedef enum logic [3:0] {
      SIZE, STEP, OFS, AMP_DC, NCYC, RNUM, RDLY, CTRL,
      TABLE = 4'd8
   } reg_idx_e;

   // ----------------------------------------
   // structs
   typedef struct packed {
      logic              we;
      logic [BUF_AW+1:0] addr;   // [11] table, [10] channel b, [9:0] index
      logic [31:0]       wdata;
   } bus_req_t;

   typedef struct packed {
      logic [PNT_W-1:0] size;     // last pointer value of the table
      logic [PNT_W-1:0] step;
      logic [PNT_W-1:0] ofs;      // start pointer
      logic [DAC_W-1:0] amp;      // unsigned, 0x2000 is unity
      logic [DAC_W-1:0] dc;       // signed offset
      logic [15:0]      ncyc;
      logic [15:0]      rnum;
      logic [31:0]      rdly;     // in ticks
      trig_src_e        trig_src;
      logic             wrap;
      logic             zero;
      logic             rst;      // one cycle pulse
   } chan_cfg_t;

   typedef struct packed {
      logic              we;
      logic [BUF_AW-1:0] addr;
      logic [DAC_W-1:0]  wdata;
   } buf_port_t;

   // clamp a wide sum into the signed dac range
   function automatic logic signed [DAC_W-1:0] sat_dac(input logic signed [DAC_W+1:0] v);
      logic [2:0] top;
      top = v[DAC_W+1 -: 3];
      if (top == 3'b000 || top == 3'b111)
         return v[DAC_W-1:0];
      return {v[DAC_W+1], {(DAC_W-1){~v[DAC_W+1]}}};   // 0x1fff or 0x2000
   endfunction

endpackage

`default_nettype wire
